//--- tb.f
rtl/l1_mem_pkg.sv
rtl/l1_byte_merge.sv
rtl/l1_word_store.sv
rtl/l1_data_pipe.sv
rtl/sim_l1_mem.sv
dv/sim_l1_mem_asserts.sv
dv/sim_l1_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the sim_l1_mem testbench with Verilator.
# Exits non-zero when the build fails or the simulation reports errors.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=sim_l1_mem_tb

echo "Building ${TOP} with Verilator"
verilator --binary --timing --assert -j 0 \
	--top-module "${TOP}" \
	--Mdir "${BUILD_DIR}" \
	-f tb.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

echo "Running simulation"
"./${BUILD_DIR}/V${TOP}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"

if grep -q "Done: errors found" "${LOG_FILE}"; then
	echo "Simulation FAILED"
	exit 1
fi

if [ ${sim_status} -ne 0 ]; then
	echo "Simulation FAILED with exit status ${sim_status}"
	exit 1
fi

if ! grep -q "Done: no errors" "${LOG_FILE}"; then
	echo "Simulation FAILED: no final result in ${LOG_FILE}"
	exit 1
fi

echo "Simulation PASSED"
exit 0

//--- dv/sim_l1_mem_tb.sv
// Testbench for the level-one memory model
// Table-driven data and fetch traffic checked against a shadow word array

`timescale 1ns/1ps
`default_nettype none

module sim_l1_mem_tb;

	import l1_mem_pkg::*;

	localparam int unsigned TB_MEM_WORDS = 1024;
	localparam int N_STIM = 25;
	localparam int TIMEOUT_CYCLES = 3 * N_STIM + 20;

	typedef logic [$clog2(TB_MEM_WORDS)-1:0] widx_t;
	typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ, OP_FETCH} op_e;
	typedef enum logic [1:0] {DSEL_RANDOM, DSEL_ONES, DSEL_ADDR} dsel_e;

	typedef struct packed {
		op_e op;
		addr_t addr;
		byte_mask_t mask;
		dsel_e dsel;
	} stim_t;

	logic clk;
	logic reset_i;
	addr_t iaddress_i;
	logic iaccess_i;
	word_t idata_o;
	addr_t daddress_i;
	logic daccess_i;
	logic dwrite_i;
	line_t ddata_i;
	byte_mask_t dwrite_mask_i;
	line_t ddata_o;
	logic dack_o;

	stim_t stim [N_STIM];
	line_t wdata [N_STIM];
	word_t shadow [TB_MEM_WORDS] = '{default: '0};
	line_t exp_ddata;
	word_t exp_idata;
	int unsigned cycle_count = 0;

	sim_l1_mem
	#(
		.MEM_WORDS(TB_MEM_WORDS)
	)
	u_sim_l1_mem
	(
		.clk(clk),
		.reset_i(reset_i),
		.iaddress_i(iaddress_i),
		.iaccess_i(iaccess_i),
		.idata_o(idata_o),
		.daddress_i(daddress_i),
		.daccess_i(daccess_i),
		.dwrite_i(dwrite_i),
		.ddata_i(ddata_i),
		.dwrite_mask_i(dwrite_mask_i),
		.ddata_o(ddata_o),
		.dack_o(dack_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$fatal(1, "Timeout");
		end
	end

	task automatic check_value(input string name, input line_t got, input line_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic stim_t make_entry(input op_e op, input addr_t addr,
		input byte_mask_t mask, input dsel_e dsel);
		stim_t e;
		e.op = op;
		e.addr = addr;
		e.mask = mask;
		e.dsel = dsel;
		return e;
	endfunction

	// Offsets 5:0 ignored and wraps past the array size
	task automatic load_table();
		stim[0] = make_entry(OP_READ, 32'h0000_0080, '0, DSEL_RANDOM);
		stim[1] = make_entry(OP_WRITE, 32'h0000_0040, '1, DSEL_RANDOM);
		stim[2] = make_entry(OP_IDLE, 32'h0000_0000, '0, DSEL_RANDOM);
		stim[3] = make_entry(OP_READ, 32'h0000_0040, '0, DSEL_RANDOM);
		stim[4] = make_entry(OP_WRITE, 32'h0000_0080, 64'h00FF_0000_F0F0_000F, DSEL_RANDOM);
		stim[5] = make_entry(OP_IDLE, 32'h0000_0000, '0, DSEL_RANDOM);
		stim[6] = make_entry(OP_READ, 32'h0000_00A3, '0, DSEL_RANDOM);
		stim[7] = make_entry(OP_WRITE, 32'h0000_00C0, '1, DSEL_ADDR);
		stim[8] = make_entry(OP_READ, 32'h0000_00C0, '0, DSEL_RANDOM);
		stim[9] = make_entry(OP_READ, 32'h0000_0040, '0, DSEL_RANDOM);
		stim[10] = make_entry(OP_READ, 32'h0000_00C0, '0, DSEL_RANDOM);
		stim[11] = make_entry(OP_READ, 32'h0000_0080, '0, DSEL_RANDOM);
		stim[12] = make_entry(OP_WRITE, 32'h0000_007F, 64'h8001_4002_2004_1008, DSEL_RANDOM);
		stim[13] = make_entry(OP_READ, 32'h1000_0040, '0, DSEL_RANDOM);
		stim[14] = make_entry(OP_FETCH, 32'h0000_0044, '0, DSEL_RANDOM);
		stim[15] = make_entry(OP_IDLE, 32'h0000_0000, '0, DSEL_RANDOM);
		stim[16] = make_entry(OP_IDLE, 32'h0000_0000, '0, DSEL_RANDOM);
		stim[17] = make_entry(OP_FETCH, 32'h0000_00BC, '0, DSEL_RANDOM);
		stim[18] = make_entry(OP_FETCH, 32'h0000_00C0, '0, DSEL_RANDOM);
		stim[19] = make_entry(OP_WRITE, 32'h0000_00C0, 64'hF000_0000_0000_0000, DSEL_ONES);
		stim[20] = make_entry(OP_IDLE, 32'h0000_0000, '0, DSEL_RANDOM);
		stim[21] = make_entry(OP_FETCH, 32'h0000_00C0, '0, DSEL_RANDOM);
		stim[22] = make_entry(OP_FETCH, 32'h0000_1000, '0, DSEL_RANDOM);
		stim[23] = make_entry(OP_READ, 32'h0000_00C0, '0, DSEL_RANDOM);
		// Untouched line after a non-zero read must come back as zero
		stim[24] = make_entry(OP_READ, 32'h0000_0100, '0, DSEL_RANDOM);
	endtask

	function automatic line_t make_wdata(input stim_t e);
		line_t data;
		addr_t base;
		base = (e.addr >> LINE_OFFSET_BITS) << LINE_OFFSET_BITS;
		data = '0;
		for (int k = 0; k < WORDS_PER_LINE; k++)
		begin
			case (e.dsel)
				DSEL_RANDOM: data[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS] = $urandom;
				DSEL_ONES: data[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS] = '1;
				default: data[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS] =
					base + addr_t'(4 * k);
			endcase
		end
		return data;
	endfunction

	// Word 0 of the line goes on top
	function automatic line_t shadow_line(input addr_t addr);
		line_t line;
		widx_t base;
		base = widx_t'((addr >> LINE_OFFSET_BITS) * WORDS_PER_LINE);
		for (int k = 0; k < WORDS_PER_LINE; k++)
			line[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS] = shadow[base + widx_t'(k)];
		return line;
	endfunction

	task automatic shadow_write(input addr_t addr, input line_t data, input byte_mask_t mask);
		line_t merged;
		widx_t base;
		merged = shadow_line(addr);
		for (int b = 0; b < BYTES_PER_LINE; b++)
		begin
			if (mask[b])
				merged[b * BYTE_BITS +: BYTE_BITS] = data[b * BYTE_BITS +: BYTE_BITS];
		end
		base = widx_t'((addr >> LINE_OFFSET_BITS) * WORDS_PER_LINE);
		for (int k = 0; k < WORDS_PER_LINE; k++)
			shadow[base + widx_t'(k)] = merged[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS];
	endtask

	task automatic drive_address(input int idx);
		stim_t e;
		e = (idx < N_STIM) ? stim[idx] : make_entry(OP_IDLE, '0, '0, DSEL_RANDOM);
		daddress_i <= e.addr;
		daccess_i <= (e.op == OP_WRITE) || (e.op == OP_READ);
		iaddress_i <= e.addr;
		iaccess_i <= (e.op == OP_FETCH);
	endtask

	// Write data phase runs in the ack cycle
	task automatic drive_data(input int idx);
		if (idx >= 0 && idx < N_STIM && stim[idx].op == OP_WRITE)
		begin
			wdata[idx] = make_wdata(stim[idx]);
			dwrite_i <= 1'b1;
			ddata_i <= wdata[idx];
			dwrite_mask_i <= stim[idx].mask;
		end
		else
		begin
			dwrite_i <= 1'b0;
			ddata_i <= '0;
			dwrite_mask_i <= '0;
		end
	endtask

	// Entry t-1 is in its ack cycle, entry t-2 has just completed
	task automatic check_cycle(input int t);
		logic exp_ack;
		exp_ack = 1'b0;
		if (t >= 1 && t - 1 < N_STIM)
		begin
			exp_ack = (stim[t-1].op == OP_WRITE) || (stim[t-1].op == OP_READ);
			if (stim[t-1].op == OP_FETCH)
				exp_idata = shadow[widx_t'(stim[t-1].addr >> WORD_OFFSET_BITS)];
		end
		check_value($sformatf("dack_o (entry %0d)", t - 1), line_t'(dack_o), line_t'(exp_ack));
		check_value($sformatf("idata_o (entry %0d)", t - 1), line_t'(idata_o),
			line_t'(exp_idata));
		if (t >= 2 && t - 2 < N_STIM)
		begin
			if (stim[t-2].op == OP_READ)
				exp_ddata = shadow_line(stim[t-2].addr);
		end
		check_value($sformatf("ddata_o (entry %0d)", t - 2), ddata_o, exp_ddata);
		if (t >= 2 && t - 2 < N_STIM && stim[t-2].op == OP_WRITE)
			shadow_write(stim[t-2].addr, wdata[t-2], stim[t-2].mask);
	endtask

	initial
	begin
		void'($urandom(88));
		reset_i <= 1'b1;
		iaddress_i <= '0;
		iaccess_i <= 1'b0;
		daddress_i <= '0;
		daccess_i <= 1'b0;
		dwrite_i <= 1'b0;
		ddata_i <= '0;
		dwrite_mask_i <= '0;
		exp_ddata = '0;
		exp_idata = '0;
		load_table();
		repeat (4) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_value("dack_o after reset", line_t'(dack_o), '0);
		check_value("ddata_o after reset", ddata_o, '0);
		check_value("idata_o after reset", line_t'(idata_o), '0);

		// Two extra cycles drain the pipeline
		for (int t = 0; t < N_STIM + 2; t++)
		begin
			@(posedge clk);
			drive_address(t);
			drive_data(t - 1);
			@(negedge clk);
			check_cycle(t);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/sim_l1_mem_asserts.sv
// Bound assertions for the level-one memory model
// Ack timing, reset state of the outputs and instruction data hold

`timescale 1ns/1ps
`default_nettype none

module sim_l1_mem_asserts
(
	input wire clk,
	input wire reset_i,
	input wire iaccess_i,
	input wire daccess_i,
	input wire l1_mem_pkg::word_t idata_o,
	input wire l1_mem_pkg::line_t ddata_o,
	input wire dack_o
);

	// Guards $past on the first edge
	logic past_valid = 1'b0;

	always @(posedge clk)
	begin
		past_valid <= 1'b1;
	end

	// Ack is the access strobe one cycle late
	a_ack_delay: assert property (@(posedge clk) disable iff (reset_i)
		past_valid && !$past(reset_i) |-> dack_o == $past(daccess_i))
		else $error("dack_o does not follow daccess_i by one cycle");

	a_reset_outputs: assert property (@(posedge clk)
		past_valid && $past(reset_i) |-> !dack_o && ddata_o == '0 && idata_o == '0)
		else $error("Outputs not cleared by reset");

	// No fetch, no change
	a_idata_hold: assert property (@(posedge clk) disable iff (reset_i)
		past_valid && !$past(reset_i) && !$past(iaccess_i) |-> $stable(idata_o))
		else $error("idata_o changed without a fetch");

endmodule

bind sim_l1_mem sim_l1_mem_asserts u_asserts
(
	.clk(clk),
	.reset_i(reset_i),
	.iaccess_i(iaccess_i),
	.daccess_i(daccess_i),
	.idata_o(idata_o),
	.ddata_o(ddata_o),
	.dack_o(dack_o)
);

`default_nettype wire

//--- rtl/sim_l1_mem.sv
// Simulation model of a level-one memory
// 32-bit instruction port and 512-bit masked data port over one word array

`timescale 1ns/1ps
`default_nettype none

module sim_l1_mem
#(
	// Array depth in words, a power of two
	parameter int unsigned MEM_WORDS = 65536
)
(
	input wire clk,
	input wire reset_i,

	// Instruction port
	input wire l1_mem_pkg::addr_t iaddress_i,
	input wire iaccess_i,
	output l1_mem_pkg::word_t idata_o,

	// Data port
	input wire l1_mem_pkg::addr_t daddress_i,
	input wire daccess_i,
	input wire dwrite_i,
	input wire l1_mem_pkg::line_t ddata_i,
	input wire l1_mem_pkg::byte_mask_t dwrite_mask_i,
	output l1_mem_pkg::line_t ddata_o,
	output logic dack_o
);

	import l1_mem_pkg::*;

	// Line traffic between the pipeline and the store
	addr_t line_addr;
	logic line_we;
	line_t line_wdata;
	line_t line_rdata;

	l1_word_store
	#(
		.MEM_WORDS(MEM_WORDS)
	)
	u_word_store
	(
		.clk(clk),
		.reset_i(reset_i),
		.iaddress_i(iaddress_i),
		.iaccess_i(iaccess_i),
		.idata_o(idata_o),
		.line_addr_i(line_addr),
		.line_rdata_o(line_rdata),
		.line_we_i(line_we),
		.line_wdata_i(line_wdata)
	);

	l1_data_pipe u_data_pipe
	(
		.clk(clk),
		.reset_i(reset_i),
		.daddress_i(daddress_i),
		.daccess_i(daccess_i),
		.dwrite_i(dwrite_i),
		.ddata_i(ddata_i),
		.dwrite_mask_i(dwrite_mask_i),
		.line_rdata_i(line_rdata),
		.line_addr_o(line_addr),
		.line_we_o(line_we),
		.line_wdata_o(line_wdata),
		.ddata_o(ddata_o),
		.dack_o(dack_o)
	);

endmodule

`default_nettype wire

//--- rtl/l1_data_pipe.sv
// Two-stage data port pipeline
// Stage 0 takes the address and strobe, stage 1 writes or reads the line

`timescale 1ns/1ps
`default_nettype none

module l1_data_pipe
(
	input wire clk,
	input wire reset_i,

	// Data port, address phase
	input wire l1_mem_pkg::addr_t daddress_i,
	input wire daccess_i,

	// Data port, ack phase
	input wire dwrite_i,
	input wire l1_mem_pkg::line_t ddata_i,
	input wire l1_mem_pkg::byte_mask_t dwrite_mask_i,

	// Line port to the store
	input wire l1_mem_pkg::line_t line_rdata_i,
	output l1_mem_pkg::addr_t line_addr_o,
	output logic line_we_o,
	output l1_mem_pkg::line_t line_wdata_o,

	// Read data and ack back to the master
	output l1_mem_pkg::line_t ddata_o,
	output logic dack_o
);

	import l1_mem_pkg::*;

	addr_t line_base;
	addr_t addr_q;
	logic access_q;

	// Offset bits inside the line are ignored
	assign line_base = {daddress_i[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

	// Stage 0 address register
	always_ff @(posedge clk)
	begin
		addr_q <= line_base;
	end

	// Stage 0 control
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			access_q <= 1'b0;
			dack_o <= 1'b0;
		end
		else
		begin
			access_q <= daccess_i;
			dack_o <= daccess_i;
		end
	end

	// Stage 1 write, master holds data and mask during the ack cycle
	assign line_addr_o = addr_q;
	assign line_we_o = access_q & dwrite_i;

	l1_byte_merge u_byte_merge
	(
		.old_line_i(line_rdata_i),
		.new_line_i(ddata_i),
		.mask_i(dwrite_mask_i),
		.merged_o(line_wdata_o)
	);

	// Stage 1 read, sees the line before any write at this edge
	always_ff @(posedge clk)
	begin
		if (reset_i)
			ddata_o <= '0;
		else if (access_q && !dwrite_i)
			ddata_o <= line_rdata_i;
	end

endmodule

`default_nettype wire

//--- rtl/l1_word_store.sv
// Word array shared by the instruction and data ports
// Registered instruction fetch, combinational line read, full line write

`timescale 1ns/1ps
`default_nettype none

module l1_word_store
#(
	parameter int unsigned MEM_WORDS = 65536
)
(
	input wire clk,
	input wire reset_i,

	// Instruction port
	input wire l1_mem_pkg::addr_t iaddress_i,
	input wire iaccess_i,
	output l1_mem_pkg::word_t idata_o,

	// Line port from the data pipeline
	input wire l1_mem_pkg::addr_t line_addr_i,
	output l1_mem_pkg::line_t line_rdata_o,
	input wire line_we_i,
	input wire l1_mem_pkg::line_t line_wdata_i
);

	import l1_mem_pkg::*;

	// Word select bits within a line
	localparam int WORD_SEL_BITS = LINE_OFFSET_BITS - WORD_OFFSET_BITS;

	// Index widths derived from the array depth
	localparam int IDX_BITS = $clog2(MEM_WORDS);
	localparam int LINE_IDX_BITS = IDX_BITS - WORD_SEL_BITS;

	typedef logic [IDX_BITS-1:0] word_idx_t;
	typedef logic [LINE_IDX_BITS-1:0] line_idx_t;
	typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

	// Storage, zero at time zero
	word_t mem [MEM_WORDS] = '{default: '0};

	word_idx_t fetch_idx;
	line_idx_t line_idx;

	// Upper address bits drop out, so accesses wrap
	assign fetch_idx = iaddress_i[WORD_OFFSET_BITS +: IDX_BITS];
	assign line_idx = line_addr_i[LINE_OFFSET_BITS +: LINE_IDX_BITS];

	// Instruction fetch
	always_ff @(posedge clk)
	begin
		if (reset_i)
			idata_o <= '0;
		else if (iaccess_i)
			idata_o <= mem[fetch_idx];
	end

	// Gather the 16 words of the line, word 0 on top
	always_comb
	begin
		for (int k = 0; k < WORDS_PER_LINE; k++)
		begin
			line_rdata_o[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS] =
				mem[{line_idx, word_sel_t'(k)}];
		end
	end

	// Line write, the caller has already merged the bytes
	always_ff @(posedge clk)
	begin
		if (line_we_i)
		begin
			for (int k = 0; k < WORDS_PER_LINE; k++)
			begin
				mem[{line_idx, word_sel_t'(k)}] <=
					line_wdata_i[(WORDS_PER_LINE - 1 - k) * WORD_BITS +: WORD_BITS];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/l1_byte_merge.sv
// Byte-wise line merge under a write mask
// A set mask bit takes the new byte, a clear one keeps the old

`timescale 1ns/1ps
`default_nettype none

module l1_byte_merge
(
	input wire l1_mem_pkg::line_t old_line_i,
	input wire l1_mem_pkg::line_t new_line_i,
	input wire l1_mem_pkg::byte_mask_t mask_i,
	output l1_mem_pkg::line_t merged_o
);

	import l1_mem_pkg::*;

	// Mask bit b covers bits 8b+7 down to 8b
	always_comb
	begin
		for (int b = 0; b < BYTES_PER_LINE; b++)
		begin
			if (mask_i[b])
				merged_o[b * BYTE_BITS +: BYTE_BITS] = new_line_i[b * BYTE_BITS +: BYTE_BITS];
			else
				merged_o[b * BYTE_BITS +: BYTE_BITS] = old_line_i[b * BYTE_BITS +: BYTE_BITS];
		end
	end

endmodule

`default_nettype wire

//--- rtl/l1_mem_pkg.sv
// Level-one memory model shared types
// Address, word, line and byte-mask widths plus line geometry

`default_nettype none

package l1_mem_pkg;

	// Basic widths
	localparam int ADDR_BITS = 32;
	localparam int WORD_BITS = 32;
	localparam int BYTE_BITS = 8;

	// Line geometry
	localparam int WORDS_PER_LINE = 16;
	localparam int LINE_BITS = WORDS_PER_LINE * WORD_BITS;
	localparam int BYTES_PER_LINE = LINE_BITS / BYTE_BITS;

	// Byte offsets inside a line and inside a word
	localparam int LINE_OFFSET_BITS = 6;
	localparam int WORD_OFFSET_BITS = 2;

	// Byte address
	typedef logic [ADDR_BITS-1:0] addr_t;

	// One memory word, also one instruction
	typedef logic [WORD_BITS-1:0] word_t;

	// Word 0 of a line lives in the top 32 bits
	typedef logic [LINE_BITS-1:0] line_t;

	// Bit 63 selects the most significant byte of a line
	typedef logic [BYTES_PER_LINE-1:0] byte_mask_t;

endpackage

`default_nettype wire
